// File: sramPkg.sv
`default_nettype none

package sramPkg;

	// one macro column per byte lane
	localparam int byteCount = 4;
	localparam int byteSize = 8;

	// word address of the whole array
	localparam int addressSize = 10;

	// address of a single 512 x 8 macro
	localparam int macroAddressSize = 9;

	// address bits above the macro range pick the bank
	localparam int bankAddressSize = addressSize - macroAddressSize;
	localparam int bankCount = 2 ** bankAddressSize;

	// rows in one macro
	localparam int macroDepth = 2 ** macroAddressSize;

	localparam int wordSize = byteSize * byteCount;

	// data word as seen by the host
	typedef logic [wordSize-1:0] word_t;

	// bit i enables byte i
	typedef logic [byteCount-1:0] mask_t;

	typedef logic [addressSize-1:0] address_t;
	typedef logic [macroAddressSize-1:0] macroAddress_t;

endpackage

`default_nettype wire

// File: sramBusIf.sv
`default_nettype none

interface sramBusIf;

	import sramPkg::*;

	// registered request, driven by the request port
	logic select;
	logic writeEnable;
	mask_t writeMask;
	address_t address;
	word_t writeData;

	// macro output, valid the cycle after a read select
	word_t readData;

	// the return stage shares this view and only looks at readData
	modport requester (
		output select,
		output writeEnable,
		output writeMask,
		output address,
		output writeData,
		input readData
	);

	modport memory (
		input select,
		input writeEnable,
		input writeMask,
		input address,
		input writeData,
		output readData
	);

endinterface

`default_nettype wire

// File: sramMacro.sv
`default_nettype none

module sramMacro (
		input wire clk,

		// active high strobes, unlike the vendor cell
		input wire chipEnable,
		input wire writeEnable,

		input wire sramPkg::macroAddress_t address,
		input wire [sramPkg::byteSize-1:0] writeData,
		output logic [sramPkg::byteSize-1:0] readData
	);

	import sramPkg::*;

	// cell array, contents undefined at power-up
	logic [byteSize-1:0] memory [macroDepth];

	// single port, so a cycle either writes or reads
	always_ff @(posedge clk) begin
		if (chipEnable) begin
			if (writeEnable) begin
				memory[address] <= writeData;
			end else begin
				readData <= memory[address];
			end
		end
	end

	// readData keeps the last read byte while the macro is idle or writing

endmodule

`default_nettype wire

// File: sramWrapper.sv
`default_nettype none

module sramWrapper (
		input wire clk,
		input wire rstN,

		sramBusIf.memory bus
	);

	import sramPkg::*;

	// bank field of the current request
	logic [bankAddressSize-1:0] requestBank;

	// row inside each macro
	macroAddress_t macroAddress;

	// bank of the last read, steers the output mux a cycle later
	logic [bankAddressSize-1:0] readBank;

	// read select seen this cycle
	logic readRequest;

	// one chip enable per bank, shared by all lanes
	logic [bankCount-1:0] bankHit;

	// byte of each lane after the bank mux
	logic [byteSize-1:0] laneData [byteCount];

	assign requestBank = bus.address[addressSize-1:macroAddressSize];
	assign macroAddress = bus.address[macroAddressSize-1:0];
	assign readRequest = bus.select && !bus.writeEnable;

	// address MSB decode
	always_comb begin
		for (int bank = 0; bank < bankCount; bank++) begin
			bankHit[bank] = bus.select && (requestBank == bankAddressSize'(bank));
		end
	end

	// the macros answer one cycle after the select,
	// so the mux has to follow the bank of that earlier read
	always_ff @(posedge clk) begin
		if (!rstN) begin
			readBank <= '0;
		end else if (readRequest) begin
			readBank <= requestBank;
		end
	end

	for (genvar lane = 0; lane < byteCount; lane++) begin : gLane

		// lane takes part in reads, and in writes only when its mask bit is set
		logic laneEnable;

		// output of each bank in this lane
		logic [byteSize-1:0] bankData [bankCount];

		// an all-zero mask leaves every macro idle
		assign laneEnable = !bus.writeEnable || bus.writeMask[lane];

		for (genvar bank = 0; bank < bankCount; bank++) begin : gBank
			sramMacro bankMacro (
				.clk(clk),
				.chipEnable(bankHit[bank] && laneEnable),
				.writeEnable(bus.writeEnable),
				.address(macroAddress),
				.writeData(bus.writeData[lane*byteSize +: byteSize]),
				.readData(bankData[bank])
			);
		end

		assign laneData[lane] = bankData[readBank];

	end

	// pack the lanes back into one word
	always_comb begin
		for (int lane = 0; lane < byteCount; lane++) begin
			bus.readData[lane*byteSize +: byteSize] = laneData[lane];
		end
	end

	// after a write the mux still points at the last read bank,
	// so readData is of no use until the next read

endmodule

`default_nettype wire

// File: sramRequestPort.sv
`default_nettype none

module sramRequestPort (
		input wire clk,
		input wire rstN,

		// host strobes, one request per cycle with select high
		input wire select,
		input wire writeEnable,
		input wire sramPkg::mask_t writeMask,
		input wire sramPkg::address_t address,
		input wire sramPkg::word_t writeData,

		sramBusIf.requester bus,

		// read tag for the return stage
		output logic readIssued,
		output sramPkg::address_t issuedAddress
	);

	// sampled request is a read
	logic isRead;

	assign isRead = select && !writeEnable;

	// control, cleared on reset
	always_ff @(posedge clk) begin
		if (!rstN) begin
			bus.select <= 1'b0;
			readIssued <= 1'b0;
		end else begin
			bus.select <= select;
			readIssued <= isRead;
		end
	end

	// payload, loaded only when a request comes in
	always_ff @(posedge clk) begin
		if (select) begin
			bus.writeEnable <= writeEnable;
			bus.writeMask <= writeMask;
			bus.address <= address;
		end
	end

	// write data only matters for writes
	always_ff @(posedge clk) begin
		if (select && writeEnable) begin
			bus.writeData <= writeData;
		end
	end

	// keep the address of each read so it can travel with the data
	always_ff @(posedge clk) begin
		if (isRead) begin
			issuedAddress <= address;
		end
	end

endmodule

`default_nettype wire

// File: sramReadReturn.sv
`default_nettype none

module sramReadReturn (
		input wire clk,
		input wire rstN,

		// read tag from the request port
		input wire readIssued,
		input wire sramPkg::address_t issuedAddress,

		// only readData is observed here
		sramBusIf.requester bus,

		output logic readValid,
		output sramPkg::address_t readAddress,
		output sramPkg::word_t readData
	);

	import sramPkg::*;

	// tag delayed to the cycle the macros drive their output
	logic pending;
	address_t pendingAddress;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			pending <= 1'b0;
		end else begin
			pending <= readIssued;
		end
	end

	always_ff @(posedge clk) begin
		if (readIssued) begin
			pendingAddress <= issuedAddress;
		end
	end

	// one cycle pulse per read
	always_ff @(posedge clk) begin
		if (!rstN) begin
			readValid <= 1'b0;
		end else begin
			readValid <= pending;
		end
	end

	// word and address are held until the next read returns
	always_ff @(posedge clk) begin
		if (pending) begin
			readAddress <= pendingAddress;
			readData <= bus.readData;
		end
	end

endmodule

`default_nettype wire

// File: sramSubsystem.sv
`default_nettype none

module sramSubsystem (
		input wire clk,
		input wire rstN,

		// host request
		input wire select,
		input wire writeEnable,
		input wire sramPkg::mask_t writeMask,
		input wire sramPkg::address_t address,
		input wire sramPkg::word_t writeData,

		// read return, three cycles after the read strobe
		output logic readValid,
		output sramPkg::address_t readAddress,
		output sramPkg::word_t readData
	);

	import sramPkg::*;

	// read tag from the port to the return stage
	logic readIssued;
	address_t issuedAddress;

	sramBusIf bus ();

	sramRequestPort requestPort (
		.clk(clk),
		.rstN(rstN),
		.select(select),
		.writeEnable(writeEnable),
		.writeMask(writeMask),
		.address(address),
		.writeData(writeData),
		.bus(bus.requester),
		.readIssued(readIssued),
		.issuedAddress(issuedAddress)
	);

	// 32 x 1024 array of eight byte macros
	sramWrapper wrapper (
		.clk(clk),
		.rstN(rstN),
		.bus(bus.memory)
	);

	sramReadReturn readReturn (
		.clk(clk),
		.rstN(rstN),
		.readIssued(readIssued),
		.issuedAddress(issuedAddress),
		.bus(bus.requester),
		.readValid(readValid),
		.readAddress(readAddress),
		.readData(readData)
	);

endmodule

`default_nettype wire

// File: sramSubsystem_properties.sv
`default_nettype none

module sramSubsystem_properties (
		input wire clk,
		input wire rstN,
		input wire select,
		input wire writeEnable,
		input wire sramPkg::mask_t writeMask,
		input wire sramPkg::address_t address,
		input wire sramPkg::word_t writeData,
		input wire readValid,
		input wire sramPkg::address_t readAddress,
		input wire sramPkg::word_t readData
	);

	timeunit 1ns;
	timeprecision 100ps;

	import sramPkg::*;

	// shadow of the array built from the host write strobes
	word_t shadow [2 ** addressSize];

	// bytes of each word that have been written at least once
	mask_t known [2 ** addressSize];

	// expected read return with one stage per cycle of latency
	logic [2:0] expValid;
	word_t expData [3];
	word_t expKnown [3];
	address_t expAddress [3];

	int timingFails = 0;
	int addressFails = 0;
	int writeFails = 0;
	int dataFails = 0;

	// seen by the testbench
	int failCount;
	logic dataBad;
	logic addressBad;
	word_t expectedData;
	word_t knownBits;
	address_t expectedAddress;

	logic isRead;
	logic isWrite;

	// widen a byte mask to one bit per data bit
	function automatic word_t byteBits(input mask_t mask);
		word_t bits;
		for (int b = 0; b < byteCount; b++) begin
			bits[b*byteSize +: byteSize] = {byteSize{mask[b]}};
		end
		return bits;
	endfunction

	assign isRead = select && !writeEnable;
	assign isWrite = select && writeEnable;

	always @(posedge clk) begin
		if (!rstN) begin
			expValid <= '0;
			for (int i = 0; i < 2 ** addressSize; i++) begin
				known[i] <= '0;
			end
		end else begin
			expValid <= {expValid[1:0], isRead};
			if (isWrite) begin
				shadow[address] <= (shadow[address] & ~byteBits(writeMask))
					| (writeData & byteBits(writeMask));
				known[address] <= known[address] | writeMask;
			end
		end
		// snapshot before this cycle's write
		// as a read and a write never share a cycle
		expData[0] <= shadow[address];
		expKnown[0] <= byteBits(known[address]);
		expAddress[0] <= address;
		expData[1] <= expData[0];
		expKnown[1] <= expKnown[0];
		expAddress[1] <= expAddress[0];
		expData[2] <= expData[1];
		expKnown[2] <= expKnown[1];
		expAddress[2] <= expAddress[1];
	end

	assign knownBits = expKnown[2];
	assign expectedData = expData[2] & expKnown[2];
	assign expectedAddress = expAddress[2];
	assign dataBad = rstN && readValid && ((readData & expKnown[2]) != expectedData);
	assign addressBad = rstN && readValid && (readAddress != expectedAddress);
	assign failCount = timingFails + addressFails + writeFails + dataFails;

	validTiming: assert property (@(posedge clk) disable iff (!rstN)
		readValid == expValid[2])
		else begin
			$error("readValid out of step with the read strobes");
			timingFails++;
		end

	readAddressMatch: assert property (@(posedge clk) !addressBad)
		else begin
			$error("readAddress is not the address of the read three cycles earlier");
			addressFails++;
		end

	writeQuiet: assert property (@(posedge clk) disable iff (!rstN)
		isWrite |-> ##3 !readValid)
		else begin
			$error("a write produced readValid");
			writeFails++;
		end

	readDataMatch: assert property (@(posedge clk) !dataBad)
		else begin
			$error("readData differs from the shadow memory");
			dataFails++;
		end

endmodule

`default_nettype wire

// File: sramSubsystem_tb.sv
`default_nettype none

module sramSubsystem_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import sramPkg::*;

	logic clk;
	logic rstN;
	logic select;
	logic writeEnable;
	mask_t writeMask;
	address_t address;
	word_t writeData;
	logic readValid;
	address_t readAddress;
	word_t readData;

	// bookkeeping per test
	int readsIssued;
	int returnsSeen = 0;
	int returnsAtStart;
	int localErrors = 0;
	int errorsAtStart;
	int testsRun = 0;
	int testsFailed = 0;
	int cycleCount = 0;
	int cycleLimit = 1000;
	logic [15:0] lfsrState;

	// cycle bound of each test with the drain included
	int testLength [6] = '{24, 20, 36, 24, 34, 320};

	sramSubsystem i_dut (
		.clk(clk),
		.rstN(rstN),
		.select(select),
		.writeEnable(writeEnable),
		.writeMask(writeMask),
		.address(address),
		.writeData(writeData),
		.readValid(readValid),
		.readAddress(readAddress),
		.readData(readData)
	);

	bind sramSubsystem sramSubsystem_properties props (
		.clk(clk),
		.rstN(rstN),
		.select(select),
		.writeEnable(writeEnable),
		.writeMask(writeMask),
		.address(address),
		.writeData(writeData),
		.readValid(readValid),
		.readAddress(readAddress),
		.readData(readData)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("timeout: the run went past %0d cycles", cycleLimit);
			$display("TESTS FAILED");
			$finish;
		end
	end

	// values here are the ones the next rising edge samples
	always @(negedge clk) begin
		if (rstN && readValid) begin
			returnsSeen <= returnsSeen + 1;
		end
		if (i_dut.props.dataBad) begin
			$display("Mismatch readData at address 0x%h: expected 0x%h, got 0x%h",
				readAddress, i_dut.props.expectedData, readData & i_dut.props.knownBits);
		end
		if (i_dut.props.addressBad) begin
			$display("Mismatch readAddress: expected 0x%h, got 0x%h",
				i_dut.props.expectedAddress, readAddress);
		end
	end

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] randomBits(input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			value = {value[30:0], lfsrState[0]};
			lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 16'hB400) : (lfsrState >> 1);
		end
		return value;
	endfunction

	function automatic int totalErrors();
		return i_dut.props.failCount + localErrors;
	endfunction

	task automatic request(input logic we, input mask_t mask, input address_t addr,
			input word_t data);
		@(posedge clk);
		select <= 1'b1;
		writeEnable <= we;
		writeMask <= mask;
		address <= addr;
		writeData <= data;
		if (!we) begin
			readsIssued++;
		end
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) begin
			@(posedge clk);
			select <= 1'b0;
			writeEnable <= 1'b0;
		end
	endtask

	task automatic startTest();
		readsIssued = 0;
		returnsAtStart = returnsSeen;
		errorsAtStart = totalErrors();
	endtask

	// wait for outstanding reads and let the last checks settle
	task automatic drainReturns();
		int waited;
		waited = 0;
		idle(1);
		while ((returnsSeen - returnsAtStart) < readsIssued && waited < 10) begin
			@(posedge clk);
			waited++;
		end
		if ((returnsSeen - returnsAtStart) < readsIssued) begin
			$display("only %0d of %0d read returns arrived",
				returnsSeen - returnsAtStart, readsIssued);
			localErrors++;
		end
		idle(4);
	endtask

	task automatic finishTest(input string name);
		int errors;
		errors = totalErrors() - errorsAtStart;
		testsRun++;
		if (errors == 0) begin
			$display("test %0d %s: ok", testsRun, name);
		end else begin
			testsFailed++;
			$display("test %0d %s: %0d errors", testsRun, name, errors);
		end
	endtask

	task automatic resetQuiet();
		startTest();
		idle(3);
		for (int n = 0; n < 3; n++) begin
			request(1'b1, 4'hF, address_t'(randomBits(addressSize)), randomBits(wordSize));
		end
		drainReturns();
		if (returnsSeen != returnsAtStart) begin
			$display("readValid was raised though no read was issued");
			localErrors++;
		end
		finishTest("quiet after reset");
	endtask

	task automatic writeThenRead();
		address_t addr;
		addr = address_t'(randomBits(addressSize));
		startTest();
		request(1'b1, 4'hF, addr, randomBits(wordSize));
		request(1'b0, 4'h0, addr, '0);
		drainReturns();
		finishTest("write then read");
	endtask

	task automatic partialMasks();
		address_t addr;
		addr = address_t'(randomBits(addressSize));
		startTest();
		request(1'b1, 4'hF, addr, randomBits(wordSize));
		request(1'b1, 4'b0101, addr, randomBits(wordSize));
		request(1'b0, 4'h0, addr, '0);
		// empty mask must leave the word alone
		request(1'b1, 4'b0000, addr, randomBits(wordSize));
		request(1'b0, 4'h0, addr, '0);
		request(1'b1, 4'b1000, addr, randomBits(wordSize));
		request(1'b0, 4'h0, addr, '0);
		request(1'b1, 4'b0010, addr, randomBits(wordSize));
		request(1'b0, 4'h0, addr, '0);
		drainReturns();
		finishTest("partial masks");
	endtask

	task automatic bankSplit();
		macroAddress_t row;
		row = macroAddress_t'(randomBits(macroAddressSize));
		startTest();
		request(1'b1, 4'hF, {1'b0, row}, randomBits(wordSize));
		request(1'b1, 4'hF, {1'b1, row}, randomBits(wordSize));
		request(1'b0, 4'h0, {1'b0, row}, '0);
		request(1'b0, 4'h0, {1'b1, row}, '0);
		request(1'b1, 4'hF, {1'b0, row}, randomBits(wordSize));
		request(1'b0, 4'h0, {1'b1, row}, '0);
		request(1'b0, 4'h0, {1'b0, row}, '0);
		drainReturns();
		finishTest("bank split");
	endtask

	task automatic alternatingReads();
		macroAddress_t rows [4];
		for (int r = 0; r < 4; r++) begin
			rows[r] = macroAddress_t'(randomBits(macroAddressSize));
		end
		startTest();
		for (int r = 0; r < 4; r++) begin
			request(1'b1, 4'hF, {1'b0, rows[r]}, randomBits(wordSize));
			request(1'b1, 4'hF, {1'b1, rows[r]}, randomBits(wordSize));
		end
		// one read per cycle with three in flight
		for (int r = 0; r < 4; r++) begin
			request(1'b0, 4'h0, {1'b0, rows[r]}, '0);
			request(1'b0, 4'h0, {1'b1, rows[r]}, '0);
		end
		drainReturns();
		finishTest("alternating bank reads");
	endtask

	task automatic randomMix();
		logic isWrite;
		logic [31:0] bankBit;
		logic [31:0] row;
		mask_t mask;
		word_t data;
		startTest();
		// 64 words over both banks so reads often hit written data
		for (int n = 0; n < 300; n++) begin
			isWrite = randomBits(1) != 0;
			bankBit = randomBits(1);
			row = randomBits(5);
			mask = mask_t'(randomBits(byteCount));
			data = randomBits(wordSize);
			request(isWrite, mask, address_t'((bankBit << (addressSize - 1)) | row), data);
		end
		drainReturns();
		finishTest("random mix");
	endtask

	initial begin
		clk = 1'b0;
		rstN = 1'b0;
		select = 1'b0;
		writeEnable = 1'b0;
		writeMask = '0;
		address = '0;
		writeData = '0;
		lfsrState = 16'd58551;
		cycleLimit = 4;
		foreach (testLength[i]) begin
			cycleLimit += testLength[i];
		end
		cycleLimit *= 2;

		repeat (4) @(posedge clk);
		rstN <= 1'b1;

		resetQuiet();
		writeThenRead();
		partialMasks();
		bankSplit();
		alternatingReads();
		randomMix();

		$display("tests run %0d, tests failed %0d, errors %0d",
			testsRun, testsFailed, totalErrors());
		if (testsFailed == 0 && totalErrors() == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
sramPkg.sv
sramBusIf.sv
sramMacro.sv
sramWrapper.sv
sramRequestPort.sv
sramReadReturn.sv
sramSubsystem.sv
sramSubsystem_properties.sv
sramSubsystem_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS = --binary --timing --assert -j 0
TOP = sramSubsystem_tb
FILELIST = all.f
SIMFLAGS = +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) $(SIMFLAGS) | awk '{ print } /^TESTS PASSED$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
